// File: src.f
hw/bfw_pkg.sv
hw/burst_req_if.sv
hw/frame_writer_ctrl.sv
hw/block_addr_gen.sv
hw/frame_buf_rotator.sv
hw/burst_write_port.sv
hw/frame_writer_top.sv
sim/frame_writer_props.sv
sim/tb_frame_checker.sv
sim/tb_frame_writer.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	-f src.f --top-module tb_frame_writer -o sim_frame_writer
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/sim_frame_writer > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Checks failed" "$LOG"; then
	exit 1
fi
exit 0

// File: sim/tb_frame_writer.sv
module tb_frame_writer;

	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int BLOCK_SIZE = 8;
	localparam int TOTAL_PIXELS = 4 * 16 * 16 + 32 * 16; // all frames of the run
	localparam int EXP_FRAMES = 5;
	localparam int WATCHDOG_CYCLES = TOTAL_PIXELS * 2 + 200;

	logic clk;
	logic rst_n = 1'b0;
	logic start_frame = 1'b0;
	bfw_pkg::dim_t frame_width = 16'd16;
	bfw_pkg::dim_t frame_height = 16'd16;
	logic [DATA_WIDTH-1:0] pix_data = '0;
	logic mem_stall = 1'b0;
	logic pix_take;
	logic mem_we;
	logic [ADDR_WIDTH-1:0] mem_addr;
	logic [DATA_WIDTH-1:0] mem_wdata;
	logic frame_ready;
	logic [ADDR_WIDTH-1:0] base_addr_out;
	logic busy;

	logic stall_en = 1'b0;
	logic [31:0] rng_state = 32'h57b5a677;
	int pix_frame = 0;
	int pix_seq = 0;
	int tb_errors = 0;
	int error_count;
	int write_count;
	int frame_count;

	frame_writer_top #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH),
		.BLOCK_SIZE(BLOCK_SIZE)
	) frame_writer_top_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.start_frame   (start_frame),
		.frame_width   (frame_width),
		.frame_height  (frame_height),
		.pix_data      (pix_data),
		.mem_stall     (mem_stall),
		.pix_take      (pix_take),
		.mem_we        (mem_we),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.frame_ready   (frame_ready),
		.base_addr_out (base_addr_out),
		.busy          (busy)
	);

	tb_frame_checker #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH),
		.BLOCK_SIZE(BLOCK_SIZE)
	) frame_check_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.start_frame   (start_frame),
		.frame_width   (frame_width),
		.frame_height  (frame_height),
		.busy          (busy),
		.pix_take      (pix_take),
		.mem_we        (mem_we),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.frame_ready   (frame_ready),
		.base_addr_out (base_addr_out),
		.error_count   (error_count),
		.write_count   (write_count),
		.frame_count   (frame_count)
	);

	bind frame_writer_top frame_writer_props #(
		.BLOCK_SIZE(BLOCK_SIZE)
	) frame_writer_props_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.mem_stall   (mem_stall),
		.mem_we      (mem_we),
		.frame_ready (frame_ready),
		.burst_start (req_if.start),
		.burst_last  (req_if.last)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [DATA_WIDTH-1:0] pix_word(input int f, input int idx);
		return DATA_WIDTH'((f << 24) | idx);
	endfunction

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin : stall_drive
		logic [31:0] rng_next;
		rng_next = lcg_step(rng_state);
		rng_state <= rng_next;
		mem_stall <= stall_en && (rng_next[31:30] == 2'b00); // about one in four
	end

	// next pixel once the current one is taken
	always @(posedge clk) begin
		if (frame_ready) begin
			pix_frame <= pix_frame + 1;
			pix_seq <= 0;
			pix_data <= pix_word(pix_frame + 1, 0);
		end else if (pix_take) begin
			pix_seq <= pix_seq + 1;
			pix_data <= pix_word(pix_frame, pix_seq + 1);
		end
	end

	task automatic run_frame(input int w, input int h, input bit stalls, input bit poke);
		@(posedge clk);
		frame_width <= bfw_pkg::dim_t'(w);
		frame_height <= bfw_pkg::dim_t'(h);
		stall_en <= stalls;
		@(posedge clk);
		start_frame <= 1'b1;
		@(posedge clk);
		start_frame <= 1'b0;
		@(posedge clk); // busy visible from here on
		if (poke) begin
			repeat (40) @(posedge clk);
			start_frame <= 1'b1; // frame still running
			@(posedge clk);
			start_frame <= 1'b0;
		end
		while (busy) begin
			@(posedge clk);
		end
		stall_en <= 1'b0;
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: frames not finished after %0d cycles", WATCHDOG_CYCLES);
		$display("Checks failed");
		$finish;
	end

	initial begin
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		run_frame(16, 16, 1'b0, 1'b0);
		run_frame(16, 16, 1'b1, 1'b0);
		run_frame(16, 16, 1'b1, 1'b0);
		run_frame(16, 16, 1'b1, 1'b0); // index wraps back to buffer 0
		run_frame(32, 16, 1'b1, 1'b1);
		repeat (4) @(posedge clk);
		if (frame_count != EXP_FRAMES) begin
			$display("mismatch full_run frame_ready pulses: expected %0d actual %0d",
				EXP_FRAMES, frame_count);
			tb_errors++;
		end
		if (write_count != TOTAL_PIXELS) begin
			$display("mismatch full_run memory writes: expected %0d actual %0d",
				TOTAL_PIXELS, write_count);
			tb_errors++;
		end
		$display("errors: checker %0d, testbench %0d; writes %0d, frames %0d",
			error_count, tb_errors, write_count, frame_count);
		if (error_count + tb_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: sim/tb_frame_checker.sv
module tb_frame_checker #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int BLOCK_SIZE = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start_frame,
	input  bfw_pkg::dim_t         frame_width,
	input  bfw_pkg::dim_t         frame_height,
	input  logic                  busy,
	input  logic                  pix_take,
	input  logic                  mem_we,
	input  logic [ADDR_WIDTH-1:0] mem_addr,
	input  logic [DATA_WIDTH-1:0] mem_wdata,
	input  logic                  frame_ready,
	input  logic [ADDR_WIDTH-1:0] base_addr_out,
	output int                    error_count,
	output int                    write_count,
	output int                    frame_count
);

	int cur_w;   // size taken at frame start
	int cur_h;
	int pix_idx; // block-order index inside the frame
	bit check_idle;

	function automatic int buffer_base(input int frame_no, input int w, input int h);
		return (frame_no % bfw_pkg::NUM_FRAMES) * w * h;
	endfunction

	// block-order pixel index to raster address
	function automatic int raster_addr(input int frame_no, input int idx, input int w, input int h);
		int blk;
		int sub;
		int x;
		int y;
		blk = idx / (BLOCK_SIZE * BLOCK_SIZE);
		sub = idx % (BLOCK_SIZE * BLOCK_SIZE);
		x = (blk % (w / BLOCK_SIZE)) * BLOCK_SIZE + sub % BLOCK_SIZE;
		y = (blk / (w / BLOCK_SIZE)) * BLOCK_SIZE + sub / BLOCK_SIZE;
		return buffer_base(frame_no, w, h) + y * w + x;
	endfunction

	function automatic logic [DATA_WIDTH-1:0] pixel_value(input int frame_no, input int idx);
		return DATA_WIDTH'((frame_no << 24) | idx); // frame in the top byte
	endfunction

	function automatic string test_name(input int frame_no);
		if (frame_no == 0) begin
			return "raster_16x16";
		end else if (frame_no < 4) begin
			return "stall_rotation";
		end
		return "resize_32x16";
	endfunction

	// outputs are settled by the falling edge
	always @(negedge clk) begin : compare
		int exp_addr;
		logic [DATA_WIDTH-1:0] exp_data;
		if (rst_n) begin
			if (start_frame && !busy) begin
				cur_w = int'(frame_width);
				cur_h = int'(frame_height);
			end
			if (pix_take !== mem_we) begin
				$display("mismatch %s pix_take: expected %b actual %b",
					test_name(frame_count), mem_we, pix_take);
				error_count++;
			end
			if (check_idle) begin
				if (busy !== 1'b0) begin
					$display("mismatch %s busy after frame_ready: expected %b actual %b",
						test_name(frame_count - 1), 1'b0, busy);
					error_count++;
				end
				check_idle = 1'b0;
			end
			if (mem_we) begin
				exp_addr = raster_addr(frame_count, pix_idx, cur_w, cur_h);
				exp_data = pixel_value(frame_count, pix_idx);
				if (!busy) begin
					$display("memory write while busy is low at time %0t", $time);
					error_count++;
				end
				if (mem_addr !== ADDR_WIDTH'(exp_addr)) begin
					$display("mismatch %s addr of pixel %0d: expected %h actual %h",
						test_name(frame_count), pix_idx, ADDR_WIDTH'(exp_addr), mem_addr);
					error_count++;
				end
				if (mem_wdata !== exp_data) begin
					$display("mismatch %s data of pixel %0d: expected %h actual %h",
						test_name(frame_count), pix_idx, exp_data, mem_wdata);
					error_count++;
				end
				pix_idx++;
				write_count++;
			end
			if (frame_ready) begin
				if (mem_we) begin
					$display("write in the same cycle as frame_ready, frame %0d", frame_count);
					error_count++;
				end
				if (pix_idx != cur_w * cur_h) begin
					$display("mismatch %s writes in frame %0d: expected %0d actual %0d",
						test_name(frame_count), frame_count, cur_w * cur_h, pix_idx);
					error_count++;
				end
				if (base_addr_out !== ADDR_WIDTH'(buffer_base(frame_count, cur_w, cur_h))) begin
					$display("mismatch %s base_addr_out: expected %h actual %h",
						test_name(frame_count),
						ADDR_WIDTH'(buffer_base(frame_count, cur_w, cur_h)), base_addr_out);
					error_count++;
				end
				frame_count++;
				pix_idx = 0;
				check_idle = 1'b1;
			end
		end
	end

endmodule

// File: sim/frame_writer_props.sv
module frame_writer_props #(
	parameter int BLOCK_SIZE = 8
) (
	input logic clk,
	input logic rst_n,
	input logic mem_stall,
	input logic mem_we,
	input logic frame_ready,
	input logic burst_start,
	input logic burst_last
);

	logic [7:0] beat_cnt; // writes seen so far in the current burst

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_cnt <= '0;
		end else if (burst_start) begin
			beat_cnt <= '0;
		end else if (mem_we) begin
			beat_cnt <= beat_cnt + 8'd1;
		end
	end

	stall_blocks_write: assert property (@(posedge clk) disable iff (!rst_n)
		mem_stall |-> !mem_we)
		else $error("memory write in a cycle with mem_stall high");

	// ready is a single-cycle pulse
	ready_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		frame_ready |=> !frame_ready)
		else $error("frame_ready held longer than one cycle");

	burst_beat_count: assert property (@(posedge clk) disable iff (!rst_n)
		burst_last |-> (beat_cnt == 8'(BLOCK_SIZE - 1)))
		else $error("burst ended after %0d writes", beat_cnt + 8'd1);

endmodule

// File: hw/frame_writer_top.sv
module frame_writer_top #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int BLOCK_SIZE = 8 // power of two
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start_frame,
	input  bfw_pkg::dim_t         frame_width,
	input  bfw_pkg::dim_t         frame_height,
	input  logic [DATA_WIDTH-1:0] pix_data,
	input  logic                  mem_stall,
	output logic                  pix_take,
	output logic                  mem_we,
	output logic [ADDR_WIDTH-1:0] mem_addr,
	output logic [DATA_WIDTH-1:0] mem_wdata,
	output logic                  frame_ready,
	output logic [ADDR_WIDTH-1:0] base_addr_out,
	output logic                  busy
);

	logic [ADDR_WIDTH-1:0] row_addr;
	logic [ADDR_WIDTH-1:0] frame_base;
	bfw_pkg::dim_t blk_col;
	bfw_pkg::dim_t blk_row;
	bfw_pkg::dim_t pix_row;
	logic frame_done;

	burst_req_if #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.BLOCK_SIZE(BLOCK_SIZE)
	) req_if ();

	assign pix_take = mem_we; // a pixel is used only when it is written

	frame_writer_ctrl #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.BLOCK_SIZE(BLOCK_SIZE)
	) frame_writer_ctrl_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.start_frame  (start_frame),
		.frame_width  (frame_width),
		.frame_height (frame_height),
		.req          (req_if.ctrl),
		.row_addr     (row_addr),
		.blk_col      (blk_col),
		.blk_row      (blk_row),
		.pix_row      (pix_row),
		.frame_done   (frame_done),
		.busy         (busy)
	);

	block_addr_gen #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.BLOCK_SIZE(BLOCK_SIZE)
	) block_addr_gen_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.frame_width (frame_width),
		.blk_col     (blk_col),
		.blk_row     (blk_row),
		.pix_row     (pix_row),
		.frame_base  (frame_base),
		.row_addr    (row_addr)
	);

	frame_buf_rotator #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) frame_buf_rotator_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.start_frame   (start_frame),
		.frame_width   (frame_width),
		.frame_height  (frame_height),
		.busy          (busy),
		.frame_done    (frame_done),
		.frame_base    (frame_base),
		.frame_ready   (frame_ready),
		.base_addr_out (base_addr_out)
	);

	burst_write_port #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH),
		.BLOCK_SIZE(BLOCK_SIZE)
	) burst_write_port_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req_if.port),
		.mem_stall (mem_stall),
		.pix_data  (pix_data),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata)
	);

endmodule

// File: hw/burst_write_port.sv
module burst_write_port #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int BLOCK_SIZE = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	burst_req_if.port             req,
	input  logic                  mem_stall,
	input  logic [DATA_WIDTH-1:0] pix_data,
	output logic                  mem_we,
	output logic [ADDR_WIDTH-1:0] mem_addr,
	output logic [DATA_WIDTH-1:0] mem_wdata
);

	localparam int LEN_WIDTH = bfw_pkg::burst_len_width(BLOCK_SIZE);
	localparam logic [LEN_WIDTH-1:0] LEN_ONE = LEN_WIDTH'(1);

	logic                  active_q; // burst in progress
	logic [ADDR_WIDTH-1:0] addr_q;
	logic [LEN_WIDTH-1:0]  left_q;   // beats still to write

	// a stalled cycle neither writes nor takes a pixel
	assign req.beat = active_q && !mem_stall;
	assign req.last = req.beat && (left_q == LEN_ONE);

	assign mem_we    = req.beat;
	assign mem_addr  = addr_q;
	assign mem_wdata = pix_data; // straight through, same cycle

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active_q <= 1'b0;
			left_q   <= '0;
		end else if (req.start) begin
			active_q <= 1'b1;
			left_q   <= req.len;
		end else if (req.beat) begin
			left_q <= left_q - LEN_ONE;
			if (req.last) begin
				active_q <= 1'b0;
			end
		end
	end

	// write address, one word per accepted beat
	always_ff @(posedge clk) begin
		if (req.start) begin
			addr_q <= req.addr;
		end else if (req.beat) begin
			addr_q <= addr_q + 1'b1;
		end
	end

endmodule

// File: hw/frame_buf_rotator.sv
module frame_buf_rotator #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start_frame,
	input  bfw_pkg::dim_t         frame_width,
	input  bfw_pkg::dim_t         frame_height,
	input  logic                  busy,
	input  logic                  frame_done,
	output logic [ADDR_WIDTH-1:0] frame_base,
	output logic                  frame_ready,
	output logic [ADDR_WIDTH-1:0] base_addr_out
);

	bfw_pkg::frame_idx_t idx_q;
	logic [ADDR_WIDTH-1:0] pix_count; // pixels per frame
	logic [ADDR_WIDTH-1:0] base_live;
	logic [ADDR_WIDTH-1:0] base_q;
	logic last_idx;

	assign pix_count = ADDR_WIDTH'(frame_width) * ADDR_WIDTH'(frame_height);
	assign base_live = ADDR_WIDTH'(idx_q) * pix_count;
	assign last_idx  = (idx_q == bfw_pkg::frame_idx_t'(bfw_pkg::NUM_FRAMES - 1));

	// while idle the address generator sees the base of the coming frame
	assign frame_base = busy ? base_q : base_live;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx_q         <= '0;
			base_q        <= '0;
			frame_ready   <= 1'b0;
			base_addr_out <= '0;
		end else begin
			frame_ready <= frame_done;
			if (start_frame && !busy) begin
				base_q <= base_live;
			end
			if (frame_done) begin
				base_addr_out <= base_q;
				idx_q         <= last_idx ? '0 : idx_q + 1'b1;
			end
		end
	end

endmodule

// File: hw/block_addr_gen.sv
module block_addr_gen #(
	parameter int ADDR_WIDTH = 32,
	parameter int BLOCK_SIZE = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  bfw_pkg::dim_t         frame_width,
	input  bfw_pkg::dim_t         blk_col,
	input  bfw_pkg::dim_t         blk_row,
	input  bfw_pkg::dim_t         pix_row,
	input  logic [ADDR_WIDTH-1:0] frame_base,
	output logic [ADDR_WIDTH-1:0] row_addr
);

	localparam int BLK_SHIFT = $clog2(BLOCK_SIZE);

	bfw_pkg::dim_t line_idx; // raster line within the frame
	bfw_pkg::dim_t col_idx;  // first column of the block
	logic [ADDR_WIDTH-1:0] line_off;
	logic [ADDR_WIDTH-1:0] addr_d;

	assign line_idx = (blk_row << BLK_SHIFT) + pix_row;
	assign col_idx  = blk_col << BLK_SHIFT;

	// only the line offset needs a real multiply
	assign line_off = ADDR_WIDTH'(line_idx) * ADDR_WIDTH'(frame_width);
	assign addr_d   = frame_base + line_off + ADDR_WIDTH'(col_idx);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row_addr <= '0;
		end else begin
			row_addr <= addr_d; // follows the counters every cycle
		end
	end

endmodule

// File: hw/frame_writer_ctrl.sv
module frame_writer_ctrl #(
	parameter int ADDR_WIDTH = 32,
	parameter int BLOCK_SIZE = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start_frame,
	input  bfw_pkg::dim_t         frame_width,
	input  bfw_pkg::dim_t         frame_height,
	burst_req_if.ctrl             req,
	input  logic [ADDR_WIDTH-1:0] row_addr,
	output bfw_pkg::dim_t         blk_col,
	output bfw_pkg::dim_t         blk_row,
	output bfw_pkg::dim_t         pix_row,
	output logic                  frame_done,
	output logic                  busy
);

	localparam int BLK_SHIFT = $clog2(BLOCK_SIZE);
	localparam int LEN_WIDTH = bfw_pkg::burst_len_width(BLOCK_SIZE);
	localparam bfw_pkg::dim_t DIM_ONE = bfw_pkg::dim_t'(1);

	bfw_pkg::wr_state_t state_q;
	bfw_pkg::wr_state_t state_d;
	bfw_pkg::dim_t cols_q; // frame size in blocks
	bfw_pkg::dim_t rows_q;
	bfw_pkg::dim_t col_q;
	bfw_pkg::dim_t col_d;
	bfw_pkg::dim_t row_q;
	bfw_pkg::dim_t row_d;
	bfw_pkg::dim_t line_q; // pixel row inside the block
	bfw_pkg::dim_t line_d;
	logic row_end;
	logic col_end;
	logic frame_end;

	assign row_end   = (line_q == bfw_pkg::dim_t'(BLOCK_SIZE - 1));
	assign col_end   = (col_q == cols_q - DIM_ONE);
	assign frame_end = row_end && col_end && (row_q == rows_q - DIM_ONE);

	// next counter values go out, so the address register
	// lines up with the counters in the start cycle
	assign blk_col = col_d;
	assign blk_row = row_d;
	assign pix_row = line_d;

	assign req.start = (state_q == bfw_pkg::REQ);
	assign req.addr  = row_addr;
	assign req.len   = LEN_WIDTH'(BLOCK_SIZE);
	assign busy      = (state_q != bfw_pkg::IDLE);

	always_comb begin
		state_d    = state_q;
		col_d      = col_q;
		row_d      = row_q;
		line_d     = line_q;
		frame_done = 1'b0;
		case (state_q)
			bfw_pkg::IDLE: begin
				if (start_frame) begin
					state_d = bfw_pkg::REQ;
				end
			end
			bfw_pkg::REQ: begin
				state_d = bfw_pkg::BURST;
			end
			bfw_pkg::BURST: begin
				if (req.last) begin
					state_d    = frame_end ? bfw_pkg::DONE : bfw_pkg::REQ;
					frame_done = frame_end;
					line_d     = row_end ? '0 : line_q + DIM_ONE;
					if (row_end) begin
						col_d = col_end ? '0 : col_q + DIM_ONE; // next block across
					end
					if (row_end && col_end) begin
						row_d = frame_end ? '0 : row_q + DIM_ONE; // wrap to next block row
					end
				end
			end
			bfw_pkg::DONE: begin
				state_d = bfw_pkg::IDLE;
			end
			default: begin
				state_d = bfw_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= bfw_pkg::IDLE;
			col_q   <= '0;
			row_q   <= '0;
			line_q  <= '0;
		end else begin
			state_q <= state_d;
			col_q   <= col_d;
			row_q   <= row_d;
			line_q  <= line_d;
		end
	end

	// frame size taken once per frame
	always_ff @(posedge clk) begin
		if (state_q == bfw_pkg::IDLE && start_frame) begin
			cols_q <= frame_width >> BLK_SHIFT;
			rows_q <= frame_height >> BLK_SHIFT;
		end
	end

endmodule

// File: hw/burst_req_if.sv
interface burst_req_if #(
	parameter int ADDR_WIDTH = 32,
	parameter int BLOCK_SIZE = 8
) ();

	localparam int LEN_WIDTH = bfw_pkg::burst_len_width(BLOCK_SIZE);

	logic                  start; // one-cycle pulse per burst
	logic [ADDR_WIDTH-1:0] addr;  // held until last
	logic [LEN_WIDTH-1:0]  len;   // beats in the burst
	logic                  beat;  // one word written this cycle
	logic                  last;  // final beat of the burst

	// control side requests bursts and watches for the end of each
	modport ctrl (
		output start,
		output addr,
		output len,
		input  last
	);

	modport port (
		input  start,
		input  addr,
		input  len,
		output beat,
		output last
	);

endinterface

// File: hw/bfw_pkg.sv
package bfw_pkg;

	localparam int DIM_WIDTH = 16;

	// three rotating frame buffers
	localparam int NUM_FRAMES = 3;

	// frame width, height or block counter
	typedef logic [DIM_WIDTH-1:0] dim_t;

	typedef logic [1:0] frame_idx_t; // 0 to NUM_FRAMES-1

	typedef enum logic [1:0] {
		IDLE,  // waiting for start_frame
		REQ,   // start pulse for the next block row
		BURST, // beats in flight
		DONE   // frame finished, ready pulse out
	} wr_state_t;

	// width of a burst length field that can hold block_size itself
	function automatic int burst_len_width(input int block_size);
		return $clog2(block_size) + 1;
	endfunction

endpackage
